// File: Bender.yml
package:
  name: pe_array

sources:
  - files:
      - src/pe_array_pkg.sv
      - src/pe_cell.sv
      - src/pe_grid.sv
      - src/array_config.sv
      - src/conv_sequencer.sv
      - src/pe_array_top.sv
  - target: test
    files:
      - test/pe_array_asserts.sv
      - test/pe_array_tb.sv

// File: pe_array.f
src/pe_array_pkg.sv
src/pe_cell.sv
src/pe_grid.sv
src/array_config.sv
src/conv_sequencer.sv
src/pe_array_top.sv
test/pe_array_asserts.sv
test/pe_array_tb.sv

// File: src/array_config.sv
`timescale 1ns/100ps

module array_config (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  pe_array_pkg::cfg_write_t             cfg,
    output pe_array_pkg::weight_map_t            weights,
    output logic [pe_array_pkg::route_width-1:0] route_sel
);

    //////////////////////////////
    // Address decode
    //////////////////////////////

    // One write enable per cell
    logic [pe_array_pkg::num_cells-1:0] cell_wr;
    // Routing register write enable
    logic                               route_wr;

    always_comb begin
        cell_wr = '0;
        for (int i = 0; i < pe_array_pkg::num_cells; i++) begin
            if (cfg.addr == pe_array_pkg::cfg_addr_width'(i)) begin
                cell_wr[i] = cfg.wr;
            end
        end
    end

    // Addresses past route_addr fall through
    assign route_wr = cfg.wr &&
        (cfg.addr == pe_array_pkg::cfg_addr_width'(pe_array_pkg::route_addr));

    //////////////////////////////
    // Weight registers
    //////////////////////////////

    // Weight view of the data word
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            weights <= '0;
        end else begin
            for (int i = 0; i < pe_array_pkg::num_cells; i++) begin
                if (cell_wr[i]) begin
                    weights[i] <= cfg.data.weight;
                end
            end
        end
    end

    //////////////////////////////
    // Routing register
    //////////////////////////////

    // Route view, low bits only, pad dropped
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            route_sel <= '0;
        end else if (route_wr) begin
            route_sel <= cfg.data.route.sel;
        end
    end

endmodule

// File: src/conv_sequencer.sv
`timescale 1ns/100ps

module conv_sequencer (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start,
    input  pe_array_pkg::psum_row_t psum_bottom,
    output logic                    busy,
    output logic                    done,
    output pe_array_pkg::psum_row_t result
);

    //////////////////////////////
    // Control state
    //////////////////////////////

    // Settle counter, counts down to zero
    logic [pe_array_pkg::cnt_width-1:0] cnt;
    // Start only taken when idle
    logic                               accept;
    // Counter expired, capture pending
    logic                               expire;

    assign accept = start && !busy;
    assign expire = busy && !done && (cnt == '0);

    // Start edge loads settle_cycles-1
    // Capture lands settle_cycles edges after start
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            done <= 1'b0;
            cnt  <= '0;
        end else if (accept) begin
            busy <= 1'b1;
            cnt  <= pe_array_pkg::cnt_width'(pe_array_pkg::settle_cycles - 1);
        end else if (done) begin
            // Busy drops one edge after done
            busy <= 1'b0;
            done <= 1'b0;
        end else if (expire) begin
            done <= 1'b1;
        end else if (busy) begin
            cnt <= cnt - 1'b1;
        end
    end

    //////////////////////////////
    // Result register
    //////////////////////////////

    // Held until the next capture
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result <= '0;
        end else if (expire) begin
            result <= psum_bottom;
        end
    end

endmodule

// File: src/pe_array_pkg.sv
package pe_array_pkg;

    //////////////////////////////
    // Array geometry
    //////////////////////////////

    localparam int num_rows    = 3;
    localparam int num_cols    = 3;
    localparam int num_cells   = num_rows * num_cols;
    // One routing bit per row below the top row
    localparam int route_width = num_rows - 1;

    // Datapath widths
    localparam int data_width = 16;
    localparam int psum_width = 32;

    //////////////////////////////
    // Configuration map
    //////////////////////////////

    localparam int cfg_addr_width = 4;
    // Cell weights sit at 0..num_cells-1, routing right after
    localparam int route_addr     = 9;

    // Settling time, covers the routed chain too
    localparam int settle_cycles = 4 * (num_rows + num_cols);
    localparam int cnt_width     = $clog2(settle_cycles);

    // Signed ifmap / weight word
    typedef logic signed [data_width-1:0] data_t;

    // Config data word, weight view or routing view
    typedef union packed {
        data_t weight;
        struct packed {
            logic [data_width-route_width-1:0] pad;
            logic [route_width-1:0]            sel;
        } route;
    } cfg_word_u;

    // Single-cycle write strobe with address and data
    typedef struct packed {
        logic                      wr;
        logic [cfg_addr_width-1:0] addr;
        cfg_word_u                 data;
    } cfg_write_t;

    // External ifmap inputs, left edge and top edge
    typedef struct packed {
        data_t [num_rows-1:0] col_in;
        data_t [num_cols-2:0] row_in;
    } edge_in_t;

    typedef logic [num_cols-1:0][psum_width-1:0] psum_row_t;

    // Index r*num_cols+c holds weight of cell (r,c)
    typedef data_t [num_cells-1:0] weight_map_t;

endpackage

// File: src/pe_array_top.sv
`timescale 1ns/100ps

module pe_array_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  pe_array_pkg::cfg_write_t cfg,
    input  pe_array_pkg::edge_in_t   edge_in,
    input  logic                     start,
    output logic                     busy,
    output logic                     done,
    output pe_array_pkg::psum_row_t  result
);

    //////////////////////////////
    // Internal wiring
    //////////////////////////////

    // Config block to grid
    pe_array_pkg::weight_map_t            weights;
    logic [pe_array_pkg::route_width-1:0] route_sel;
    // Grid to sequencer
    pe_array_pkg::psum_row_t              psum_bottom;

    // Weight and routing registers
    array_config u_config (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg       (cfg),
        .weights   (weights),
        .route_sel (route_sel)
    );

    // Systolic MAC grid
    pe_grid u_grid (
        .clk         (clk),
        .rst_n       (rst_n),
        .edge_in     (edge_in),
        .weights     (weights),
        .route_sel   (route_sel),
        .psum_bottom (psum_bottom)
    );

    // Start, settle, capture
    conv_sequencer u_seq (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .psum_bottom (psum_bottom),
        .busy        (busy),
        .done        (done),
        .result      (result)
    );

endmodule

// File: src/pe_cell.sv
`timescale 1ns/100ps

module pe_cell (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic [pe_array_pkg::data_width-1:0] ifmap_in,
    input  logic [pe_array_pkg::psum_width-1:0] psum_in,
    input  logic [pe_array_pkg::data_width-1:0] weight,
    output logic [pe_array_pkg::data_width-1:0] ifmap_out,
    output logic [pe_array_pkg::psum_width-1:0] psum_out
);

    //////////////////////////////
    // Multiply
    //////////////////////////////

    // Signed product, sign extended to psum width
    logic signed [pe_array_pkg::psum_width-1:0] product;

    // 16x16 fits exactly in 32 bits
    assign product = $signed(ifmap_in) * $signed(weight);

    //////////////////////////////
    // Diagonal ifmap register
    //////////////////////////////

    // One cycle to the next cell down-right
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ifmap_out <= '0;
        end else begin
            ifmap_out <= ifmap_in;
        end
    end

    //////////////////////////////
    // Partial sum register
    //////////////////////////////

    // Accumulate into the column chain
    // Sum wraps modulo 2^32
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            psum_out <= '0;
        end else begin
            psum_out <= psum_in + product;
        end
    end

endmodule

// File: src/pe_grid.sv
`timescale 1ns/100ps

module pe_grid (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  pe_array_pkg::edge_in_t               edge_in,
    input  pe_array_pkg::weight_map_t            weights,
    input  logic [pe_array_pkg::route_width-1:0] route_sel,
    output pe_array_pkg::psum_row_t              psum_bottom
);

    //////////////////////////////
    // Interconnect nets
    //////////////////////////////

    // Ifmap into and out of each cell
    logic [pe_array_pkg::data_width-1:0] ifmap_in_w
        [pe_array_pkg::num_rows][pe_array_pkg::num_cols];
    logic [pe_array_pkg::data_width-1:0] ifmap_out_w
        [pe_array_pkg::num_rows][pe_array_pkg::num_cols];

    // Partial sum into and out of each cell
    logic [pe_array_pkg::psum_width-1:0] psum_in_w
        [pe_array_pkg::num_rows][pe_array_pkg::num_cols];
    logic [pe_array_pkg::psum_width-1:0] psum_out_w
        [pe_array_pkg::num_rows][pe_array_pkg::num_cols];

    //////////////////////////////
    // Cell array
    //////////////////////////////

    for (genvar r = 0; r < pe_array_pkg::num_rows; r++) begin : g_row
        for (genvar c = 0; c < pe_array_pkg::num_cols; c++) begin : g_col

            // Ifmap source for this cell
            if (r == 0 && c == 0) begin : g_origin
                // Corner takes the first left-edge input
                assign ifmap_in_w[r][c] = edge_in.col_in[0];
            end else if (r == 0) begin : g_top
                // Top edge, column 1 onward
                assign ifmap_in_w[r][c] = edge_in.row_in[c-1];
            end else if (c == 0) begin : g_left
                // Left edge mux
                // Routed: right edge of the row above
                assign ifmap_in_w[r][c] = route_sel[r-1]
                    ? ifmap_out_w[r-1][pe_array_pkg::num_cols-1]
                    : edge_in.col_in[r];
            end else begin : g_diag
                // Interior, diagonal neighbour
                assign ifmap_in_w[r][c] = ifmap_out_w[r-1][c-1];
            end

            // Top row starts the column sum at zero
            if (r == 0) begin : g_psum_top
                assign psum_in_w[r][c] = '0;
            end else begin : g_psum_chain
                assign psum_in_w[r][c] = psum_out_w[r-1][c];
            end

            pe_cell u_cell (
                .clk       (clk),
                .rst_n     (rst_n),
                .ifmap_in  (ifmap_in_w[r][c]),
                .psum_in   (psum_in_w[r][c]),
                .weight    (weights[r*pe_array_pkg::num_cols+c]),
                .ifmap_out (ifmap_out_w[r][c]),
                .psum_out  (psum_out_w[r][c])
            );
        end
    end

    //////////////////////////////
    // Bottom edge
    //////////////////////////////

    // Column sums leave at the last row
    for (genvar c = 0; c < pe_array_pkg::num_cols; c++) begin : g_bottom
        assign psum_bottom[c] = psum_out_w[pe_array_pkg::num_rows-1][c];
    end

endmodule

// File: test/pe_array_asserts.sv
`timescale 1ns/100ps

module pe_array_asserts (
    input logic                    clk,
    input logic                    rst_n,
    input logic                    busy,
    input logic                    done,
    input pe_array_pkg::psum_row_t result
);

    // Failed assertions so far
    int fail_count = 0;

    //////////////////////////////
    // Sequencer handshake
    //////////////////////////////

    // Done is a single-cycle pulse
    done_pulse: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
        else begin
            fail_count++;
            $error("done stayed high for more than one cycle");
        end

    // Done only inside a busy window
    done_in_busy: assert property (@(posedge clk) disable iff (!rst_n) done |-> busy)
        else begin
            fail_count++;
            $error("done pulsed while busy was low");
        end

    // Busy drops on the edge after done
    busy_falls: assert property (@(posedge clk) disable iff (!rst_n) done |=> !busy)
        else begin
            fail_count++;
            $error("busy still high one cycle after done");
        end

    //////////////////////////////
    // Reset state
    //////////////////////////////

    // Idle and cleared on the first edge out of reset
    reset_idle: assert property (@(posedge clk)
        $rose(rst_n) |-> (!busy && !done && result == '0))
        else begin
            fail_count++;
            $error("busy, done or result not cleared after reset");
        end

endmodule

bind pe_array_top pe_array_asserts u_asserts (
    .clk    (clk),
    .rst_n  (rst_n),
    .busy   (busy),
    .done   (done),
    .result (result)
);

// File: test/pe_array_tb.sv
`timescale 1ns/100ps

module pe_array_tb;

    localparam int num_cases    = 13;
    localparam int reset_cycles = 16;
    // Generous bound on the wait for done
    localparam int done_limit = pe_array_pkg::settle_cycles + 8;
    localparam int watchdog_cycles =
        reset_cycles + num_cases * (pe_array_pkg::settle_cycles + 20);

    // One table entry with values and control flags
    typedef struct packed {
        pe_array_pkg::weight_map_t            weights;
        logic [pe_array_pkg::route_width-1:0] route;
        pe_array_pkg::edge_in_t               edge_vals;
        logic                                 rand_vals;
        logic                                 reuse_prev;
        logic                                 skip_config;
        logic                                 junk_writes;
        logic                                 second_start;
        logic                                 same_prev;
        logic                                 differ_prev;
    } case_t;

    logic                       clk;
    logic                       rst_n;
    logic                       start;
    pe_array_pkg::cfg_write_t   cfg;
    pe_array_pkg::edge_in_t     edge_val;
    logic                       busy;
    logic                       done;
    pe_array_pkg::psum_row_t    result;

    case_t                   case_table [num_cases];
    case_t                   last_case;
    pe_array_pkg::psum_row_t last_result;
    logic [31:0]             rng_state;
    int                      mismatch_count;
    int                      protocol_count;
    int                      assert_count;

    pe_array_top DUT (
        .clk     (clk),
        .rst_n   (rst_n),
        .cfg     (cfg),
        .edge_in (edge_val),
        .start   (start),
        .busy    (busy),
        .done    (done),
        .result  (result)
    );

    //////////////////////////////
    // Clock and watchdog
    //////////////////////////////

    initial clk = 1'b0;
    always #4 clk = ~clk;

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("watchdog expired after %0d cycles, run did not finish", watchdog_cycles);
        $display(">>> FAIL");
        $finish;
    end

    //////////////////////////////
    // Helpers
    //////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] v;
        v = s;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    // Distinct value on every edge input
    function automatic pe_array_pkg::edge_in_t ramp_edges(input logic [15:0] base);
        pe_array_pkg::edge_in_t e;
        for (int i = 0; i < pe_array_pkg::num_rows; i++) begin
            e.col_in[i] = base + 16'(i * 16'h0111);
        end
        for (int j = 0; j < pe_array_pkg::num_cols - 1; j++) begin
            e.row_in[j] = base + 16'h0040 + 16'(j * 16'h0111);
        end
        return e;
    endfunction

    // Reference model from the steady-state ifmap of each cell
    function automatic pe_array_pkg::psum_row_t model_result(
        input pe_array_pkg::weight_map_t            w,
        input logic [pe_array_pkg::route_width-1:0] route,
        input pe_array_pkg::edge_in_t               e
    );
        pe_array_pkg::data_t     x [pe_array_pkg::num_rows][pe_array_pkg::num_cols];
        pe_array_pkg::psum_row_t sums;
        int                      acc;
        for (int r = 0; r < pe_array_pkg::num_rows; r++) begin
            // Left edge may come from the row above
            if (r == 0) begin
                x[r][0] = e.col_in[0];
            end else if (route[r-1]) begin
                x[r][0] = x[r-1][pe_array_pkg::num_cols-1];
            end else begin
                x[r][0] = e.col_in[r];
            end
            for (int c = 1; c < pe_array_pkg::num_cols; c++) begin
                if (r < c) begin
                    x[r][c] = e.row_in[c-r-1];
                end else begin
                    x[r][c] = x[r-c][0];
                end
            end
        end
        // Weighted column sums
        for (int c = 0; c < pe_array_pkg::num_cols; c++) begin
            acc = 0;
            for (int r = 0; r < pe_array_pkg::num_rows; r++) begin
                acc = acc + int'(w[r*pe_array_pkg::num_cols+c]) * int'(x[r][c]);
            end
            sums[c] = acc;
        end
        return sums;
    endfunction

    task automatic draw_random_values(inout case_t tc);
        for (int i = 0; i < pe_array_pkg::num_cells; i++) begin
            rng_state = xorshift32(rng_state);
            tc.weights[i] = rng_state[15:0];
        end
        for (int i = 0; i < pe_array_pkg::num_rows; i++) begin
            rng_state = xorshift32(rng_state);
            tc.edge_vals.col_in[i] = rng_state[31:16];
        end
        for (int j = 0; j < pe_array_pkg::num_cols - 1; j++) begin
            rng_state = xorshift32(rng_state);
            tc.edge_vals.row_in[j] = rng_state[31:16];
        end
    endtask

    // Entered and left 1 ns after a rising edge
    task automatic write_cfg(
        input logic [pe_array_pkg::cfg_addr_width-1:0] addr,
        input pe_array_pkg::cfg_word_u                 data
    );
        cfg.wr   = 1'b1;
        cfg.addr = addr;
        cfg.data = data;
        @(posedge clk);
        #1;
        cfg = '0;
    endtask

    //////////////////////////////
    // Case table
    //////////////////////////////

    task automatic build_table();
        for (int i = 0; i < num_cases; i++) begin
            case_table[i] = '0;
        end
        // Reset weights with no writes at all
        case_table[0].skip_config = 1'b1;
        case_table[0].edge_vals   = ramp_edges(16'h0123);
        // Cell (0,0) from col_in[0]
        case_table[1].weights[0]  = 16'hfffd;
        case_table[1].edge_vals   = ramp_edges(16'h0007);
        // Cell (2,1) on the diagonal from col_in[1]
        case_table[2].weights[7]  = 16'h0005;
        case_table[2].edge_vals   = ramp_edges(16'h8001);
        // Cell (0,2) from row_in[1]
        case_table[3].weights[2]  = 16'h1234;
        case_table[3].edge_vals   = ramp_edges(16'h00ab);
        // Cell (1,2) on the diagonal from row_in[0]
        case_table[4].weights[5]  = 16'hff00;
        case_table[4].edge_vals   = ramp_edges(16'h0102);
        // Cell (2,0) from col_in[2]
        case_table[5].weights[6]  = 16'h7fff;
        case_table[5].edge_vals   = ramp_edges(16'hc350);
        // Random values without routing
        case_table[6].rand_vals    = 1'b1;
        case_table[7].rand_vals    = 1'b1;
        case_table[7].second_start = 1'b1;
        // Fully routed and then the same values unrouted
        case_table[8].rand_vals    = 1'b1;
        case_table[8].route        = 2'b11;
        case_table[9].reuse_prev   = 1'b1;
        case_table[9].differ_prev  = 1'b1;
        // Only unused addresses so the result repeats
        case_table[10].reuse_prev  = 1'b1;
        case_table[10].skip_config = 1'b1;
        case_table[10].junk_writes = 1'b1;
        case_table[10].same_prev   = 1'b1;
        // Partly routed
        case_table[11].rand_vals   = 1'b1;
        case_table[11].route       = 2'b01;
        case_table[12].rand_vals   = 1'b1;
        case_table[12].route       = 2'b10;
    endtask

    //////////////////////////////
    // One case
    //////////////////////////////

    task automatic run_case(input int idx);
        case_t                   tc;
        pe_array_pkg::cfg_word_u word;
        pe_array_pkg::psum_row_t expected;
        int                      cycles;
        tc = case_table[idx];
        if (tc.reuse_prev) begin
            tc.weights   = last_case.weights;
            tc.edge_vals = last_case.edge_vals;
        end else if (tc.rand_vals) begin
            draw_random_values(tc);
        end
        if (!tc.skip_config) begin
            for (int i = 0; i < pe_array_pkg::num_cells; i++) begin
                word.weight = tc.weights[i];
                write_cfg(pe_array_pkg::cfg_addr_width'(i), word);
            end
            word = '0;
            word.route.sel = tc.route;
            write_cfg(pe_array_pkg::cfg_addr_width'(pe_array_pkg::route_addr), word);
        end
        // Random data at 10..15
        if (tc.junk_writes) begin
            for (int a = pe_array_pkg::route_addr + 1; a < 16; a++) begin
                rng_state = xorshift32(rng_state);
                word = rng_state[15:0];
                write_cfg(pe_array_pkg::cfg_addr_width'(a), word);
            end
        end
        expected = model_result(tc.weights, tc.route, tc.edge_vals);
        edge_val = tc.edge_vals;
        start = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        assert (busy === 1'b1) else begin
            protocol_count++;
            $display("case %0d: busy did not rise after start", idx);
        end
        // Wait for done with an optional stray start
        cycles = 0;
        while (done !== 1'b1 && cycles < done_limit) begin
            start = tc.second_start && (cycles == 4);
            @(posedge clk);
            #1;
            cycles++;
        end
        start = 1'b0;
        assert (done === 1'b1) else begin
            protocol_count++;
            $display("case %0d: done never arrived within %0d cycles", idx, done_limit);
        end
        assert (cycles == pe_array_pkg::settle_cycles) else begin
            mismatch_count++;
            $display("MISMATCH case %0d done_latency: got 0x%0h expected 0x%0h",
                     idx, cycles, pe_array_pkg::settle_cycles);
        end
        for (int c = 0; c < pe_array_pkg::num_cols; c++) begin
            assert (result[c] === expected[c]) else begin
                mismatch_count++;
                $display("MISMATCH case %0d result[%0d]: got 0x%08h expected 0x%08h",
                         idx, c, result[c], expected[c]);
            end
        end
        if (tc.same_prev) begin
            assert (result === last_result) else begin
                mismatch_count++;
                $display("MISMATCH case %0d result: got 0x%h expected 0x%h",
                         idx, result, last_result);
            end
        end
        if (tc.differ_prev) begin
            assert (result !== last_result) else begin
                protocol_count++;
                $display("case %0d: routed and unrouted results are identical", idx);
            end
        end
        @(posedge clk);
        #1;
        assert (busy === 1'b0 && done === 1'b0) else begin
            protocol_count++;
            $display("case %0d: busy or done still high one cycle after done", idx);
        end
        // Ignored start must not bring a second done
        if (tc.second_start) begin
            repeat (6) begin
                @(posedge clk);
                #1;
                assert (done !== 1'b1) else begin
                    protocol_count++;
                    $display("case %0d: extra done after a start pulsed while busy", idx);
                end
            end
        end
        last_case   = tc;
        last_result = result;
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin
        rst_n          = 1'b0;
        start          = 1'b0;
        cfg            = '0;
        edge_val       = '0;
        rng_state      = 32'hab42dbfc;
        mismatch_count = 0;
        protocol_count = 0;
        assert_count   = 0;
        last_case      = '0;
        last_result    = '0;
        build_table();
        repeat (reset_cycles) @(posedge clk);
        #1;
        rst_n = 1'b1;
        assert (busy === 1'b0 && done === 1'b0 && result === '0) else begin
            protocol_count++;
            $display("busy, done or result not cleared after reset");
        end
        for (int i = 0; i < num_cases; i++) begin
            run_case(i);
        end
        // Failures of the bound protocol checker
        assert_count = DUT.u_asserts.fail_count;
        $display("errors: %0d mismatches, %0d protocol failures, %0d assertion failures",
                 mismatch_count, protocol_count, assert_count);
        if (mismatch_count == 0 && protocol_count == 0 && assert_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
